// ==== proc_params.svh ====
// Sizing macros for the 16-bit five-stage processor core
// Include this in every package, RTL module and testbench file of the core
// Types built on these values live in isaPkg and pipePkg
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Datapath
`define PROC_WIDTH      16   // Data and instruction word width
`define PROC_NREGS      8    // Architectural registers

// Memories, both word addressed
`define PROC_IMEM_DEPTH 256  // Instruction words
`define PROC_DMEM_DEPTH 256  // Data words

`endif

// ==== isaPkg.sv ====
// Instruction set definitions for the 16-bit teaching core
// Opcodes, R-format functions, ALU operations and the two instruction views
// Modules refer to these types as isaPkg::name
`include "proc_params.svh"

package isaPkg;

    typedef logic [$clog2(`PROC_NREGS)-1:0] regAddrT;  // Register index

    // Bits 15..11 of every instruction
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        ADDI  = 5'b01000,
        BEQZ  = 5'b01100,
        ST    = 5'b10000,
        LD    = 5'b10001,
        RTYPE = 5'b11011
    } opcodeE;  // Any other value is illegal

    typedef enum logic [1:0] {
        F_ADD = 2'b00,
        F_SUB = 2'b01,  // rs minus rt
        F_XOR = 2'b10,
        F_AND = 2'b11
    } functE;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,  // Also used for address generation
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } aluOpE;

    typedef struct packed {
        opcodeE  opcode;  // 15..11
        regAddrT rs;      // 10..8
        regAddrT rt;      // 7..5
        regAddrT rd;      // 4..2
        functE   funct;   // 1..0
    } rFmtT;

    typedef struct packed {
        opcodeE     opcode;  // 15..11
        regAddrT    rs;      // 10..8
        regAddrT    rd;      // 7..5, store data register for ST
        logic [4:0] imm5;    // Signed
    } iFmtT;

    // Same word seen both ways; bits 7..5 feed read port B in either view
    typedef union packed {
        rFmtT r;
        iFmtT i;
    } instrU;

endpackage

// ==== pipePkg.sv ====
// Pipeline register layouts for the five-stage core
// One packed struct per stage boundary plus the decoded control bundle
// The top level declares one register of each type
`include "proc_params.svh"

package pipePkg;

    typedef logic [`PROC_WIDTH-1:0] wordT;

    typedef struct packed {
        isaPkg::aluOpE aluOp;
        logic          useImm;    // Operand B from immediate
        logic          memRead;   // LD
        logic          memWrite;  // ST
        logic          regWrite;
    } ctrlT;

    typedef struct packed {
        logic          valid;  // Cleared on squash
        wordT          pc;     // Address of instr
        isaPkg::instrU instr;
    } ifIdT;

    typedef struct packed {
        logic            valid;
        ctrlT            ctrl;
        wordT            rsVal;
        wordT            rtVal;   // Operand B or store data
        wordT            imm;     // Already sign extended
        isaPkg::regAddrT wrAddr;
    } idExT;

    typedef struct packed {
        logic            valid;
        ctrlT            ctrl;
        wordT            aluOut;  // Result or memory address
        wordT            rtVal;   // Store data
        isaPkg::regAddrT wrAddr;
    } exMemT;

    typedef struct packed {
        logic            valid;
        logic            regWrite;
        wordT            wbData;
        isaPkg::regAddrT wrAddr;
    } memWbT;

endpackage

// ==== control.sv ====
// Decode-stage control for the five-stage core
// Turns the IF/ID instruction into controls, write address and immediate,
// resolves BEQZ, and holds the sticky halt state that freezes fetch
`include "proc_params.svh"

module control (
    input  logic                     clk,
    input  logic                     rst,
    input  pipePkg::ifIdT            ifId,
    input  logic [`PROC_WIDTH-1:0]   rsVal,
    input  logic [`PROC_WIDTH-1:0]   rtVal,
    output pipePkg::ctrlT            ctrl,
    output isaPkg::regAddrT          wrAddr,
    output logic [`PROC_WIDTH-1:0]   imm,
    output logic                     decValid,
    output logic                     branchTaken,
    output logic [`PROC_WIDTH-1:0]   branchTarget,
    output logic                     squash,
    output logic                     freeze,
    output logic                     err
);

    logic           haltQ;  // Set once HALT has decoded
    logic           live;   // Real instruction in decode
    logic           legal;
    logic           isHalt;
    isaPkg::opcodeE op;

    assign op     = ifId.instr.r.opcode;  // Same bits in both views
    assign live   = ifId.valid && !haltQ;  // Everything after HALT is a bubble
    assign isHalt = live && (op == isaPkg::HALT);

    always_comb begin
        ctrl  = '0;  // Bubble, aluOp add
        legal = 1'b1;
        case (op)
            isaPkg::NOP, isaPkg::HALT, isaPkg::BEQZ: legal = 1'b1;  // No datapath work
            isaPkg::RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (ifId.instr.r.funct)
                    isaPkg::F_ADD: ctrl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::F_SUB: ctrl.aluOp = isaPkg::ALU_SUB;
                    isaPkg::F_XOR: ctrl.aluOp = isaPkg::ALU_XOR;
                    default:       ctrl.aluOp = isaPkg::ALU_AND;
                endcase
            end
            isaPkg::ADDI: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::LD: begin
                ctrl.useImm   = 1'b1;  // Address is rs plus imm
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::ST: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;  // Data comes through rtVal
            end
            default: legal = 1'b0;  // Unknown opcode
        endcase
    end

    assign wrAddr = (op == isaPkg::RTYPE) ? ifId.instr.r.rd : ifId.instr.i.rd;
    assign imm    = {{(`PROC_WIDTH-5){ifId.instr.i.imm5[4]}}, ifId.instr.i.imm5};

    assign decValid     = live && legal && (op != isaPkg::HALT);  // HALT never retires
    assign err          = live && !legal;  // One cycle per illegal word
    assign branchTaken  = live && (op == isaPkg::BEQZ) && (rsVal == '0);
    assign branchTarget = ifId.pc + imm + 1'b1;
    assign squash       = branchTaken;  // Kills the fetch behind the branch
    assign freeze       = haltQ || isHalt;  // Rises with HALT in decode

    always_ff @(posedge clk) begin
        if (rst) begin
            haltQ <= 1'b0;
        end else if (isHalt) begin
            haltQ <= 1'b1;  // Held until reset
        end
    end

    // Fetch never gets a redirect and a hold together
    a_noBranchWhenFrozen: assert property (@(posedge clk) disable iff (rst)
        !(branchTaken && freeze));

    // Register file must hand decode known data for BEQZ and ST
    a_knownOperands: assert property (@(posedge clk) disable iff (rst)
        live && (op == isaPkg::ST || op == isaPkg::BEQZ) |-> !$isunknown({rsVal, rtVal}));

endmodule

// ==== fetchUnit.sv ====
// Fetch stage of the five-stage core
// Holds the program counter and the instruction memory, which is loaded
// through a write port while the core sits in reset
`include "proc_params.svh"

module fetchUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   branchTaken,
    input  logic [`PROC_WIDTH-1:0] branchTarget,
    input  logic                   freeze,
    input  logic                   instrWe,
    input  logic [`PROC_WIDTH-1:0] instrAddr,
    input  logic [`PROC_WIDTH-1:0] instrData,
    output logic [`PROC_WIDTH-1:0] pc,
    output isaPkg::instrU          instr
);

    localparam int idxW = $clog2(`PROC_IMEM_DEPTH);

    logic [`PROC_WIDTH-1:0] imem [`PROC_IMEM_DEPTH];  // No reset
    logic [`PROC_WIDTH-1:0] pcNext;

    // Program load port
    always_ff @(posedge clk) begin
        if (instrWe) begin
            imem[instrAddr[idxW-1:0]] <= instrData;
        end
    end

    always_comb begin
        if (freeze) begin
            pcNext = pc;  // Hold after HALT
        end else if (branchTaken) begin
            pcNext = branchTarget;  // Resolved in decode
        end else begin
            pcNext = pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign instr = imem[pc[idxW-1:0]];  // Combinational read

    // Programs must stay inside instruction memory
    a_pcInRange: assert property (@(posedge clk) disable iff (rst)
        pc < `PROC_IMEM_DEPTH);

endmodule

// ==== regFile.sv ====
// Register file with eight 16-bit registers
// Two combinational read ports for decode and one write port for writeback
// A write shows on the read ports in the same cycle
`include "proc_params.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  isaPkg::regAddrT        rdAddrA,
    input  isaPkg::regAddrT        rdAddrB,
    output logic [`PROC_WIDTH-1:0] rdDataA,
    output logic [`PROC_WIDTH-1:0] rdDataB,
    input  logic                   wrEn,
    input  isaPkg::regAddrT        wrAddr,
    input  logic [`PROC_WIDTH-1:0] wrData
);

    logic [`PROC_WIDTH-1:0] regs [`PROC_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `PROC_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through bypass
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    // Writeback data from the memory stage must be clean
    a_knownWrite: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> !$isunknown(wrData));

endmodule

// ==== alu.sv ====
// Execute-stage ALU
// Second operand is rtVal or the sign-extended immediate
// Results wrap modulo 2^16; LD and ST use the add for addressing
`include "proc_params.svh"

module alu (
    input  pipePkg::idExT          idEx,
    output logic [`PROC_WIDTH-1:0] aluOut
);

    logic [`PROC_WIDTH-1:0] opA;
    logic [`PROC_WIDTH-1:0] opB;

    assign opA = idEx.rsVal;
    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtVal;  // I-format takes imm

    always_comb begin
        case (idEx.ctrl.aluOp)
            isaPkg::ALU_ADD: aluOut = opA + opB;  // Carry dropped
            isaPkg::ALU_SUB: aluOut = opA - opB;
            isaPkg::ALU_AND: aluOut = opA & opB;
            isaPkg::ALU_XOR: aluOut = opA ^ opB;
            default:         aluOut = opA + opB;
        endcase
    end

endmodule

// ==== dataMem.sv ====
// Data memory for LD and ST
// Word addressed by the low bits of the ALU result
// Reads are combinational, writes land at the clock edge
`include "proc_params.svh"

module dataMem #(
    parameter int depth = `PROC_DMEM_DEPTH
) (
    input  logic                   clk,
    input  pipePkg::exMemT         exMem,
    output logic [`PROC_WIDTH-1:0] rdData
);

    localparam int idxW = $clog2(depth);

    logic [`PROC_WIDTH-1:0] mem [depth];  // Contents undefined until stored

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            mem[exMem.aluOut[idxW-1:0]] <= exMem.rtVal;  // ST
        end
    end

    assign rdData = mem[exMem.aluOut[idxW-1:0]];

endmodule

// ==== proc.sv ====
// Top level of the five-stage pipelined 16-bit core
// Holds the IF/ID, ID/EX, EX/MEM and MEM/WB registers and wires the stages
// Program words go in through instrWe while rst is high; the retire trace
// and halted come out for checking
`include "proc_params.svh"

module proc (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrWe,
    input  logic [`PROC_WIDTH-1:0] instrAddr,
    input  logic [`PROC_WIDTH-1:0] instrData,
    output logic                   wbValid,
    output isaPkg::regAddrT        wbReg,
    output logic [`PROC_WIDTH-1:0] wbData,
    output logic                   halted,
    output logic                   err
);

    pipePkg::ifIdT  ifId;  // Stage registers
    pipePkg::idExT  idEx;
    pipePkg::exMemT exMem;
    pipePkg::memWbT memWb;

    // Fetch
    logic [`PROC_WIDTH-1:0] pc;
    isaPkg::instrU          instr;

    // Decode
    logic [`PROC_WIDTH-1:0] rsVal;
    logic [`PROC_WIDTH-1:0] rtVal;
    pipePkg::ctrlT          ctrl;
    isaPkg::regAddrT        wrAddr;
    logic [`PROC_WIDTH-1:0] imm;
    logic                   decValid;
    logic                   branchTaken;
    logic [`PROC_WIDTH-1:0] branchTarget;
    logic                   squash;
    logic                   freeze;

    // Execute, memory, writeback
    logic [`PROC_WIDTH-1:0] aluOut;
    logic [`PROC_WIDTH-1:0] memRdData;
    logic [`PROC_WIDTH-1:0] wbDataNext;
    logic                   wbEn;
    logic [3:0]             haltDly;  // HALT decode to writeback plus one

    fetchUnit i_fetchUnit (
        .clk         (clk),
        .rst         (rst),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .freeze      (freeze),
        .instrWe     (instrWe),
        .instrAddr   (instrAddr),
        .instrData   (instrData),
        .pc          (pc),
        .instr       (instr)
    );

    regFile i_regFile (
        .clk    (clk),
        .rst    (rst),
        .rdAddrA(ifId.instr.r.rs),
        .rdAddrB(ifId.instr.r.rt),  // Bits 7..5 in both formats
        .rdDataA(rsVal),
        .rdDataB(rtVal),
        .wrEn   (wbEn),
        .wrAddr (memWb.wrAddr),
        .wrData (memWb.wbData)
    );

    control i_control (
        .clk         (clk),
        .rst         (rst),
        .ifId        (ifId),
        .rsVal       (rsVal),
        .rtVal       (rtVal),
        .ctrl        (ctrl),
        .wrAddr      (wrAddr),
        .imm         (imm),
        .decValid    (decValid),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .squash      (squash),
        .freeze      (freeze),
        .err         (err)
    );

    alu i_alu (
        .idEx  (idEx),
        .aluOut(aluOut)
    );

    dataMem #(.depth(`PROC_DMEM_DEPTH)) i_dataMem (
        .clk   (clk),
        .exMem (exMem),
        .rdData(memRdData)
    );

    assign wbDataNext = exMem.ctrl.memRead ? memRdData : exMem.aluOut;  // LD takes memory
    assign wbEn       = memWb.valid && memWb.regWrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            ifId    <= '0;
            idEx    <= '0;
            exMem   <= '0;
            memWb   <= '0;
            haltDly <= '0;
        end else begin
            ifId.valid <= !squash;  // Bubble behind a taken branch
            ifId.pc    <= pc;
            ifId.instr <= instr;

            idEx.valid  <= decValid;
            idEx.ctrl   <= ctrl;
            idEx.rsVal  <= rsVal;
            idEx.rtVal  <= rtVal;
            idEx.imm    <= imm;
            idEx.wrAddr <= wrAddr;

            exMem.valid  <= idEx.valid;
            exMem.ctrl   <= idEx.ctrl;
            exMem.aluOut <= aluOut;
            exMem.rtVal  <= idEx.rtVal;
            exMem.wrAddr <= idEx.wrAddr;

            memWb.valid    <= exMem.valid;
            memWb.regWrite <= exMem.ctrl.regWrite;
            memWb.wbData   <= wbDataNext;
            memWb.wrAddr   <= exMem.wrAddr;

            haltDly <= {haltDly[2:0], freeze};  // Freeze is sticky so halted stays up
        end
    end

    // Retire trace, one register write per cycle
    assign wbValid = wbEn;
    assign wbReg   = memWb.wrAddr;
    assign wbData  = memWb.wbData;
    assign halted  = haltDly[3];

endmodule

// ==== procTb.sv ====
// Testbench for the five-stage 16-bit core
// Reads program words and the expected retire trace from proc_vectors.txt,
// loads the program while the core is in reset, then checks every retire,
// the err pulse count and halted against the vectors
`include "proc_params.svh"

module procTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst;
    logic                   instrWe;
    logic [`PROC_WIDTH-1:0] instrAddr;
    logic [`PROC_WIDTH-1:0] instrData;
    logic                   wbValid;
    isaPkg::regAddrT        wbReg;
    logic [`PROC_WIDTH-1:0] wbData;
    logic                   halted;
    logic                   err;

    logic [`PROC_WIDTH-1:0] progAddr [$];  // From I lines
    logic [`PROC_WIDTH-1:0] progData [$];
    isaPkg::regAddrT        expReg [$];    // From W lines, in retire order
    logic [`PROC_WIDTH-1:0] expData [$];
    int                     expErr;        // From the E line

    int  valueErrs;
    int  otherErrs;
    int  retired;
    int  errPulses;  // Cycles with err high
    bit  vectorsOk;

    proc i_proc (
        .clk      (clk),
        .rst      (rst),
        .instrWe  (instrWe),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted),
        .err      (err)
    );

    always #50 clk = ~clk;  // 100 ns period

    // Tag letter starts each line, # starts a comment up to end of line
    task automatic readVectors(output bit ok);
        int                fd;
        int                c;
        int                a;
        int                d;
        int                n;
        logic [8*128-1:0]  rest;
        ok = 1'b0;
        fd = $fopen("proc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open proc_vectors.txt for reading");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    n = $fgets(rest, fd);  // Skip comment text
                end else if (c == "I") begin
                    n = $fscanf(fd, "%h %h", a, d);
                    if (n != 2) begin
                        $display("Malformed program line in proc_vectors.txt");
                        otherErrs++;
                    end
                    progAddr.push_back(a[`PROC_WIDTH-1:0]);
                    progData.push_back(d[`PROC_WIDTH-1:0]);
                end else if (c == "W") begin
                    n = $fscanf(fd, "%h %h", a, d);
                    if (n != 2) begin
                        $display("Malformed retire line in proc_vectors.txt");
                        otherErrs++;
                    end
                    expReg.push_back(a[2:0]);
                    expData.push_back(d[`PROC_WIDTH-1:0]);
                end else if (c == "E") begin
                    n = $fscanf(fd, "%d", expErr);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            ok = (progAddr.size() > 0);
            if (!ok) begin
                $display("No program words found in proc_vectors.txt");
            end
        end
    endtask

    // Reset covers the load and then 8 more cycles
    task automatic loadProgram();
        for (int k = 0; k < progAddr.size(); k++) begin
            @(posedge clk);
            #10;
            instrWe   = 1'b1;
            instrAddr = progAddr[k];
            instrData = progData[k];
        end
        @(posedge clk);
        #10;
        instrWe = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
    endtask

    task automatic checkRetire();
        isaPkg::regAddrT        eReg;
        logic [`PROC_WIDTH-1:0] eData;
        if (expReg.size() == 0) begin
            $display("Unexpected retire of r%0d = %h after the last expected entry",
                     wbReg, wbData);
            otherErrs++;
        end else begin
            eReg  = expReg.pop_front();
            eData = expData.pop_front();
            if (wbReg !== eReg) begin
                $display("error: wbReg expected %h got %h at retire %0d", eReg, wbReg, retired);
                valueErrs++;
            end
            if (wbData !== eData) begin
                $display("error: wbData expected %h got %h at retire %0d", eData, wbData,
                         retired);
                valueErrs++;
            end
        end
        retired++;
    endtask

    task automatic sampleOutputs();
        if (err) begin
            errPulses++;
        end
        if (wbValid) begin
            checkRetire();
        end
    endtask

    // Sample mid-cycle on the falling edge where outputs are settled
    task automatic runProgram();
        int cycles;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            sampleOutputs();
        end
        if (!halted) begin
            $display("Timed out: halted did not rise within 2000 cycles");
            otherErrs++;
        end else begin
            repeat (10) begin  // Frozen core must stay quiet
                @(negedge clk);
                sampleOutputs();
                if (!halted) begin
                    $display("halted dropped after it had risen");
                    otherErrs++;
                end
            end
            if (expReg.size() != 0) begin
                $display("%0d expected retires never appeared", expReg.size());
                otherErrs++;
            end
            if (errPulses != expErr) begin
                $display("error: err pulses expected %h got %h", expErr, errPulses);
                valueErrs++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        instrWe   = 1'b0;
        instrAddr = '0;
        instrData = '0;
        expErr    = 0;
        valueErrs = 0;
        otherErrs = 0;
        retired   = 0;
        errPulses = 0;

        readVectors(vectorsOk);
        if (vectorsOk) begin
            loadProgram();
            runProgram();
        end else begin
            otherErrs++;
        end

        $display("Summary: %0d value errors, %0d other errors, %0d retires, %0d err cycles",
                 valueErrs, otherErrs, retired, errPulses);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== proc_vectors.txt ====
# I addr data : program word, both hex
# W reg data  : expected retire in order, both hex ; E count : expected err cycles, decimal
I 0000 4025  # addi r1 r0 5
I 0001 405D  # addi r2 r0 -3
I 0002 406F  # addi r3 r0 15
I 0003 4190  # addi r4 r1 -16
I 0004 D954  # add r5 r1 r2
I 0005 DA79  # sub r6 r2 r3
I 0006 DA7F  # and r7 r2 r3
I 0007 DC66  # xor r1 r4 r3
I 0008 80A3  # st r5 to r0+3
I 0009 83C1  # st r6 to r3+1
I 000A 0800  # nop
I 000B 8843  # ld r2 from r0+3
I 000C 8BE1  # ld r7 from r3+1
I 000D 6002  # beqz r0 +2 taken
I 000E 40C1  # squashed addi r6
I 000F 40C2  # skipped addi r6
I 0010 6201  # beqz r2 +1 not taken
I 0011 41C1  # addi r6 r1 1
I 0012 F800  # illegal opcode
I 0013 40A7  # addi r5 r0 7
I 0014 0000  # halt
I 0015 4089  # never retires
I 0016 4061  # never retires
W 1 0005
W 2 FFFD
W 3 000F
W 4 FFF5
W 5 0002
W 6 FFEE
W 7 000D
W 1 FFFA
W 2 0002
W 7 FFEE
W 6 FFFB
W 5 0007
E 1

// ==== project.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
control.sv
fetchUnit.sv
regFile.sv
alu.sv
dataMem.sv
proc.sv
procTb.sv

// ==== Bender.yml ====
package:
  name: proc

sources:
  - include_dirs:
      - .
    files:
      - isaPkg.sv
      - pipePkg.sv
      - control.sv
      - fetchUnit.sv
      - regFile.sv
      - alu.sv
      - dataMem.sv
      - proc.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - procTb.sv
